/* hdl/db_pkg.sv */
// ==========================================================================
// Shared widths, command and status codes, and channel payload structs for
// the key/value fabric. Import it by wildcard in each module header.
// ==========================================================================
package db_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // 4-bit key gives 16 entries per table
    localparam int KEY_WID   = 4;
    localparam int VALUE_WID = 32;

    typedef logic [KEY_WID-1:0]   key_t;
    typedef logic [VALUE_WID-1:0] value_t;

    // ======================================================================
    // Codes
    // ======================================================================

    // Commands carried on the request side of a channel
    typedef enum logic [1:0] {
        // Answered with an error
        CMD_NOP   = 2'd0,
        // Read an entry
        CMD_GET   = 2'd1,
        // Write an entry and mark it valid
        CMD_SET   = 2'd2,
        // Clear the valid bit of an entry
        CMD_UNSET = 2'd3
    } command_t;

    // Completion status returned with each ack
    typedef enum logic [1:0] {
        STATUS_OK          = 2'd0,
        // NOP or a command the table does not know
        STATUS_ERROR       = 2'd1,
        // Driven while no response is being returned
        STATUS_UNSPECIFIED = 2'd2
    } status_t;

    // ======================================================================
    // Payloads
    // ======================================================================

    // Controller to peripheral, 38 bits
    typedef struct packed {
        command_t command;
        key_t     key;
        value_t   set_value;
    } db_req_t;

    // Peripheral to controller, 39 bits
    typedef struct packed {
        status_t  status;
        logic     get_valid;
        key_t     get_key;
        value_t   get_value;
    } db_resp_t;

endpackage : db_pkg

/* hdl/db_prio_arb.sv */
// ==========================================================================
// Strict-priority arbiter joining the hi and lo controller channels onto one
// shared channel. The grant is held from acceptance until the ack returns.
// ==========================================================================
`timescale 1ns/1ps

module db_prio_arb
    import db_pkg::*;
#(
    parameter type req_t  = db_req_t,
    parameter type resp_t = db_resp_t
) (
    input  logic  clk,
    input  logic  srst,

    // High-priority controller
    input  logic  hi_req,
    input  req_t  hi_data,
    output logic  hi_rdy,
    output logic  hi_ack,
    output resp_t hi_resp,

    // Low-priority controller
    input  logic  lo_req,
    input  req_t  lo_data,
    output logic  lo_rdy,
    output logic  lo_ack,
    output resp_t lo_resp,

    // Shared channel toward the router
    output logic  out_req,
    output req_t  out_data,
    input  logic  out_rdy,
    input  logic  out_ack,
    input  resp_t out_resp,

    // Open transaction, holds the routing register
    output logic  busy
);

    // ======================================================================
    // Grant
    // ======================================================================

    logic pending;
    logic grant_lo_q;
    logic grant_lo;
    logic accept;

    // Free decision only when nothing is open, hi wins ties
    assign grant_lo = pending ? grant_lo_q : !hi_req;

    always_ff @(posedge clk) begin
        if (srst) begin
            grant_lo_q <= 1'b0;
        end else begin
            grant_lo_q <= grant_lo;
        end
    end

    assign accept = out_req && out_rdy;

    // Open from acceptance until the peripheral acks
    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
        end else if (out_ack) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end
    end

    // Acceptance cycle counts too, so the route cannot move under it
    assign busy = pending || accept;

    // ======================================================================
    // Data path
    // ======================================================================

    assign out_req  = grant_lo ? lo_req  : hi_req;
    assign out_data = grant_lo ? lo_data : hi_data;

    // Ungranted side sees no rdy and no ack
    assign hi_rdy = out_rdy && !grant_lo;
    assign hi_ack = out_ack && !grant_lo;
    assign lo_rdy = out_rdy && grant_lo;
    assign lo_ack = out_ack && grant_lo;

    // Response is only meaningful alongside ack
    assign hi_resp = out_resp;
    assign lo_resp = out_resp;

    // A stray ack from downstream would be routed to an arbitrary side
    a_ack_needs_pending : assert property (@(posedge clk) disable iff (srst)
        out_ack |-> pending);

endmodule : db_prio_arb

/* hdl/db_route_cfg.sv */
// ==========================================================================
// Routing register selecting which table the shared channel reaches.
// Writes land one cycle later and are dropped while a transaction is open.
// ==========================================================================
`timescale 1ns/1ps

module db_route_cfg #(
    parameter int num_tables = 2
) (
    input  logic clk,
    input  logic srst,
    input  logic route_wr,
    input  logic [7:0] route_table,
    input  logic busy,
    output logic [(num_tables > 1 ? $clog2(num_tables) : 1)-1:0] sel
);

    localparam int sel_wid = (num_tables > 1) ? $clog2(num_tables) : 1;

    // ======================================================================
    // Select register
    // ======================================================================

    logic [7:0] route_mod;

    // Out-of-range writes wrap onto an existing table
    assign route_mod = route_table % 8'(num_tables);

    always_ff @(posedge clk) begin
        if (srst) begin
            sel <= '0;
        end else if (route_wr && !busy) begin
            sel <= sel_wid'(route_mod);
        end
    end

    // Moving the route mid-transaction would lose the ack of the old table
    a_sel_stable_busy : assert property (@(posedge clk) disable iff (srst)
        busy |=> $stable(sel));

endmodule : db_route_cfg

/* hdl/db_demux.sv */
// ==========================================================================
// Router from the shared channel to one of several tables. The request goes
// to the selected table only; its rdy, ack and response come back.
// ==========================================================================
`timescale 1ns/1ps

module db_demux
    import db_pkg::*;
#(
    parameter int  num_tables = 2,
    parameter type req_t      = db_req_t,
    parameter type resp_t     = db_resp_t
) (
    input  logic [(num_tables > 1 ? $clog2(num_tables) : 1)-1:0] sel,

    // Shared channel from the arbiter
    input  logic  in_req,
    input  req_t  in_data,
    output logic  in_rdy,
    output logic  in_ack,
    output resp_t in_resp,

    // Table side
    output logic [num_tables-1:0] tbl_req,
    output req_t                  tbl_data,
    input  logic [num_tables-1:0] tbl_rdy,
    input  logic [num_tables-1:0] tbl_ack,
    input  resp_t                 tbl_resp [num_tables]
);

    // ======================================================================
    // Request side
    // ======================================================================

    // Unselected tables see req low
    always_comb begin
        tbl_req      = '0;
        tbl_req[sel] = in_req;
    end

    // Payload goes to every table and req qualifies it
    assign tbl_data = in_data;

    // ======================================================================
    // Reply side
    // ======================================================================

    assign in_rdy  = tbl_rdy[sel];
    assign in_ack  = tbl_ack[sel];
    assign in_resp = tbl_resp[sel];

    // Two tables taking one request would both ack it
    always_comb begin
        a_req_onehot : assert ($onehot0(tbl_req));
    end

endmodule : db_demux

/* hdl/db_table.sv */
// ==========================================================================
// Key/value table peripheral with a valid bit per entry. Executes GET, SET
// and UNSET on acceptance and acks with the response one cycle later.
// ==========================================================================
`timescale 1ns/1ps

module db_table
    import db_pkg::*;
(
    input  logic     clk,
    input  logic     srst,
    input  logic     req,
    input  db_req_t  data,
    output logic     rdy,
    output logic     ack,
    output db_resp_t resp
);

    localparam int NUM_ENTRIES = 2**KEY_WID;

    // ======================================================================
    // Storage
    // ======================================================================

    value_t                 mem [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] valid_bits;
    logic                   accept;

    // rdy drops for the ack cycle, one transaction at a time
    assign rdy    = !ack;
    assign accept = req && rdy;

    always_ff @(posedge clk) begin
        if (accept && data.command == CMD_SET) begin
            mem[data.key] <= data.set_value;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            valid_bits <= '0;
        end else if (accept) begin
            if (data.command == CMD_SET) begin
                valid_bits[data.key] <= 1'b1;
            end else if (data.command == CMD_UNSET) begin
                valid_bits[data.key] <= 1'b0;
            end
        end
    end

    // ======================================================================
    // Response
    // ======================================================================

    db_resp_t resp_next;
    db_resp_t resp_q;

    // Read happens before the write of the same edge, harmless since
    // a GET never coincides with a SET
    always_comb begin
        resp_next.status    = STATUS_OK;
        resp_next.get_valid = 1'b0;
        resp_next.get_key   = data.key;
        resp_next.get_value = '0;
        case (data.command)
            CMD_GET: begin
                resp_next.get_valid = valid_bits[data.key];
                resp_next.get_value = mem[data.key];
            end
            CMD_SET, CMD_UNSET: begin
                resp_next.status = STATUS_OK;
            end
            default: begin
                resp_next.status = STATUS_ERROR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_q <= resp_next;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;
        end
    end

    // Idle value outside the ack cycle
    always_comb begin
        if (ack) begin
            resp = resp_q;
        end else begin
            resp = '{status: STATUS_UNSPECIFIED, get_valid: 1'b0, get_key: '0, get_value: '0};
        end
    end

    a_ack_after_accept : assert property (@(posedge clk) disable iff (srst)
        ack |-> $past(req && rdy));

endmodule : db_table

/* hdl/db_subsys.sv */
// ==========================================================================
// Top level of the key/value fabric: two controllers, the priority arbiter,
// the routing register, the router and num_tables tables.
// ==========================================================================
`timescale 1ns/1ps

module db_subsys
    import db_pkg::*;
#(
    parameter int num_tables = 2
) (
    input  logic       clk,
    input  logic       srst,
    input  logic       hi_req,
    input  db_req_t    hi_data,
    output logic       hi_rdy,
    output logic       hi_ack,
    output db_resp_t   hi_resp,
    input  logic       lo_req,
    input  db_req_t    lo_data,
    output logic       lo_rdy,
    output logic       lo_ack,
    output db_resp_t   lo_resp,
    input  logic       route_wr,
    input  logic [7:0] route_table
);

    localparam int sel_wid = (num_tables > 1) ? $clog2(num_tables) : 1;

    // Shared channel between arbiter and router
    logic     sh_req;
    db_req_t  sh_data;
    logic     sh_rdy;
    logic     sh_ack;
    db_resp_t sh_resp;
    logic     busy;

    logic [sel_wid-1:0] sel;

    // Table side of the router
    logic [num_tables-1:0] tbl_req;
    db_req_t               tbl_data;
    logic [num_tables-1:0] tbl_rdy;
    logic [num_tables-1:0] tbl_ack;
    db_resp_t              tbl_resp [num_tables];

    db_prio_arb #(.req_t(db_req_t), .resp_t(db_resp_t)) u_arb (
        .clk(clk), .srst(srst),
        .hi_req(hi_req), .hi_data(hi_data), .hi_rdy(hi_rdy), .hi_ack(hi_ack), .hi_resp(hi_resp),
        .lo_req(lo_req), .lo_data(lo_data), .lo_rdy(lo_rdy), .lo_ack(lo_ack), .lo_resp(lo_resp),
        .out_req(sh_req), .out_data(sh_data), .out_rdy(sh_rdy), .out_ack(sh_ack),
        .out_resp(sh_resp), .busy(busy)
    );

    db_route_cfg #(.num_tables(num_tables)) u_route (
        .clk(clk), .srst(srst), .route_wr(route_wr), .route_table(route_table),
        .busy(busy), .sel(sel)
    );

    db_demux #(.num_tables(num_tables), .req_t(db_req_t), .resp_t(db_resp_t)) u_demux (
        .sel(sel), .in_req(sh_req), .in_data(sh_data), .in_rdy(sh_rdy), .in_ack(sh_ack),
        .in_resp(sh_resp), .tbl_req(tbl_req), .tbl_data(tbl_data), .tbl_rdy(tbl_rdy),
        .tbl_ack(tbl_ack), .tbl_resp(tbl_resp)
    );

    for (genvar t = 0; t < num_tables; t++) begin : g_table
        db_table u_table (
            .clk(clk), .srst(srst), .req(tbl_req[t]), .data(tbl_data),
            .rdy(tbl_rdy[t]), .ack(tbl_ack[t]), .resp(tbl_resp[t])
        );
    end

endmodule : db_subsys

/* verif/tb_db_subsys.sv */
// ==========================================================================
// Testbench for the key/value fabric. It drives both controller ports,
// keeps a reference model per table and checks every ack with assertions.
// ==========================================================================
`timescale 1ns/1ps

module tb_db_subsys
    import db_pkg::*;
;

    localparam int NUM_TABLES  = 2;
    localparam int TBL_WID     = (NUM_TABLES > 1) ? $clog2(NUM_TABLES) : 1;
    localparam int CLK_PERIOD  = 20;
    localparam int TEST_CYCLES = 150;
    localparam bit SIDE_HI     = 1'b0;
    localparam bit SIDE_LO     = 1'b1;

    logic       clk;
    logic       srst;
    logic       hi_req;
    db_req_t    hi_data;
    logic       hi_rdy;
    logic       hi_ack;
    db_resp_t   hi_resp;
    logic       lo_req;
    db_req_t    lo_data;
    logic       lo_rdy;
    logic       lo_ack;
    db_resp_t   lo_resp;
    logic       route_wr;
    logic [7:0] route_table;

    db_subsys #(.num_tables(NUM_TABLES)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // Reference model
    // ======================================================================

    value_t                          model_value [NUM_TABLES][16];
    logic [NUM_TABLES-1:0][15:0]     model_valid;
    logic [TBL_WID-1:0]              route_exp;
    logic                            hi_open;
    logic                            lo_open;
    db_req_t                         hi_cmd_req;
    db_req_t                         lo_cmd_req;
    logic [TBL_WID-1:0]              hi_tbl;
    logic [TBL_WID-1:0]              lo_tbl;
    logic                            accepting;
    db_req_t                         done_req;
    db_resp_t                        done_resp;
    logic [TBL_WID-1:0]              done_tbl;
    logic                            done_match;

    int errors   = 0;
    int err_mark = 0;
    int passed   = 0;
    int failed   = 0;
    logic [31:0] rng_state = 32'd20;

    // Expected reply from the table rules; value only matters for a valid GET
    function automatic bit resp_matches(input db_resp_t r, input db_req_t q,
                                        input logic vbit, input value_t v);
        bit ok;
        ok = (r.get_key == q.key);
        case (q.command)
            CMD_GET: begin
                ok = ok && r.status == STATUS_OK && r.get_valid == vbit;
                if (vbit) begin
                    ok = ok && r.get_value == v;
                end
            end
            CMD_SET, CMD_UNSET: ok = ok && r.status == STATUS_OK && !r.get_valid;
            default: ok = ok && r.status == STATUS_ERROR && !r.get_valid;
        endcase
        return ok;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic void flag_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endfunction

    assign accepting  = (hi_req && hi_rdy) || (lo_req && lo_rdy);
    // Only one side can be in its ack cycle at a time
    assign done_req   = hi_ack ? hi_cmd_req : lo_cmd_req;
    assign done_tbl   = hi_ack ? hi_tbl : lo_tbl;
    assign done_resp  = hi_ack ? hi_resp : lo_resp;
    assign done_match = resp_matches(done_resp, done_req, model_valid[done_tbl][done_req.key],
                                     model_value[done_tbl][done_req.key]);

    always @(posedge clk) begin
        if (srst) begin
            hi_open     <= 1'b0;
            lo_open     <= 1'b0;
            route_exp   <= '0;
            model_valid <= '0;
        end else begin
            if (hi_req && hi_rdy) begin
                hi_open    <= 1'b1;
                hi_cmd_req <= hi_data;
                hi_tbl     <= route_exp;
            end else if (hi_ack) begin
                hi_open <= 1'b0;
            end
            if (lo_req && lo_rdy) begin
                lo_open    <= 1'b1;
                lo_cmd_req <= lo_data;
                lo_tbl     <= route_exp;
            end else if (lo_ack) begin
                lo_open <= 1'b0;
            end
            // Route only moves while nothing is open or being accepted
            if (route_wr && !(hi_open || lo_open || accepting)) begin
                route_exp <= TBL_WID'(route_table % 8'(NUM_TABLES));
            end
            if (hi_ack || lo_ack) begin
                if (done_req.command == CMD_SET) begin
                    model_value[done_tbl][done_req.key] <= done_req.set_value;
                    model_valid[done_tbl][done_req.key] <= 1'b1;
                end else if (done_req.command == CMD_UNSET) begin
                    model_valid[done_tbl][done_req.key] <= 1'b0;
                end
            end
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    a_hi_timing : assert property (@(posedge clk) disable iff (srst)
        hi_req && hi_rdy |=> hi_ack) else flag_error("hi ack not 1 cycle after acceptance");
    a_lo_timing : assert property (@(posedge clk) disable iff (srst)
        lo_req && lo_rdy |=> lo_ack) else flag_error("lo ack not 1 cycle after acceptance");
    a_hi_stray : assert property (@(posedge clk) disable iff (srst)
        hi_ack |-> hi_open) else flag_error("hi ack without an open transaction");
    a_lo_stray : assert property (@(posedge clk) disable iff (srst)
        lo_ack |-> lo_open) else flag_error("lo ack without an open transaction");
    a_resp : assert property (@(posedge clk) disable iff (srst)
        (hi_ack || lo_ack) |-> done_match) else flag_error("response differs from model");
    a_idle_ready : assert property (@(posedge clk) disable iff (srst)
        !hi_open && !lo_open |-> (hi_req ? hi_rdy : lo_rdy))
        else flag_error("idle fabric not ready for the requesting side");
    a_priority : assert property (@(posedge clk) disable iff (srst)
        hi_req && !lo_open |-> !lo_rdy) else flag_error("lo ready while hi requests");
    a_hi_holds : assert property (@(posedge clk) disable iff (srst)
        hi_open |-> !lo_rdy && !lo_ack) else flag_error("lo served during hi transaction");
    a_lo_holds : assert property (@(posedge clk) disable iff (srst)
        lo_open |-> !hi_rdy && !hi_ack) else flag_error("hi served during lo transaction");

    // ======================================================================
    // Stimulus
    // ======================================================================

    // Called 2 ns after a rising edge, returns 2 ns after the ack cycle
    task automatic run_txn(input bit use_lo, input command_t cmd, input key_t key,
                           input value_t val);
        db_req_t q;
        q.command   = cmd;
        q.key       = key;
        q.set_value = val;
        if (use_lo) begin
            lo_data = q;
            lo_req  = 1'b1;
        end else begin
            hi_data = q;
            hi_req  = 1'b1;
        end
        do @(negedge clk); while (!(use_lo ? lo_rdy : hi_rdy));
        @(posedge clk);
        #2;
        if (use_lo) begin
            lo_req = 1'b0;
        end else begin
            hi_req = 1'b0;
        end
        do @(negedge clk); while (!(use_lo ? lo_ack : hi_ack));
        @(posedge clk);
        #2;
    endtask

    task automatic set_route(input logic [7:0] table_idx);
        route_wr    = 1'b1;
        route_table = table_idx;
        @(posedge clk);
        #2;
        route_wr = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            passed++;
            $display("Test %s: pass", name);
        end else begin
            failed++;
            $display("Test %s: fail, %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin : stimulus
        key_t   keys [$];
        value_t v;
        srst        = 1'b1;
        hi_req      = 1'b0;
        hi_data     = '0;
        lo_req      = 1'b0;
        lo_data     = '0;
        route_wr    = 1'b0;
        route_table = '0;
        repeat (10) @(posedge clk);
        #2;
        srst = 1'b0;

        repeat (3) @(posedge clk);
        #2;
        for (int k = 0; k < 4; k++) begin
            run_txn(SIDE_HI, CMD_GET, key_t'(k * 5), '0);
        end
        finish_test("reset_state");

        repeat (8) begin
            keys.push_back(key_t'(next_random()));
            run_txn(SIDE_HI, CMD_SET, keys[$], next_random());
        end
        foreach (keys[i]) run_txn(SIDE_HI, CMD_GET, keys[i], '0);
        finish_test("set_get");

        run_txn(SIDE_HI, CMD_UNSET, keys[0], '0);
        run_txn(SIDE_HI, CMD_GET, keys[0], '0);
        run_txn(SIDE_HI, CMD_SET, keys[1], next_random());
        run_txn(SIDE_HI, CMD_NOP, keys[1], next_random());
        run_txn(SIDE_LO, CMD_GET, keys[1], '0);
        finish_test("unset_nop");

        set_route(8'd1);
        keys.delete();
        repeat (4) begin
            keys.push_back(key_t'(next_random()));
            run_txn(SIDE_HI, CMD_SET, keys[$], next_random());
        end
        foreach (keys[i]) run_txn(SIDE_HI, CMD_GET, keys[i], '0);
        set_route(8'd0);
        foreach (keys[i]) run_txn(SIDE_LO, CMD_GET, keys[i], '0);
        // 3 wraps onto table 1
        set_route(8'd3);
        run_txn(SIDE_HI, CMD_GET, keys[0], '0);
        run_txn(SIDE_HI, CMD_GET, keys[1], '0);
        route_wr    = 1'b1;
        route_table = 8'd0;
        run_txn(SIDE_HI, CMD_GET, keys[2], '0);
        route_wr = 1'b0;
        run_txn(SIDE_HI, CMD_GET, keys[3], '0);
        finish_test("routing");

        v = next_random();
        fork
            run_txn(SIDE_HI, CMD_SET, 4'd9, v);
            run_txn(SIDE_LO, CMD_GET, 4'd9, '0);
        join
        v = next_random();
        fork
            run_txn(SIDE_LO, CMD_SET, 4'd10, v);
            begin
                @(posedge clk);
                #2;
                run_txn(SIDE_HI, CMD_GET, 4'd10, '0);
            end
        join
        finish_test("priority");

        repeat (4) @(posedge clk);
        $display("Tests passed: %0d, failed: %0d, check errors: %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 40 * CLK_PERIOD);
        $display("Timeout: the tests did not complete within %0d clock periods",
                 TEST_CYCLES * 40);
        $display("Finished with errors");
        $finish;
    end

endmodule : tb_db_subsys

/* sim.f */
hdl/db_pkg.sv
hdl/db_prio_arb.sv
hdl/db_route_cfg.sv
hdl/db_demux.sv
hdl/db_table.sv
hdl/db_subsys.sv
verif/tb_db_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the key/value fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_db_subsys --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_db_subsys > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "Result: PASS"
    exit 0
fi
echo "Result: FAIL"
exit 1
